// ==== logic/apb_word_regs.sv ====
// APB word register block
`timescale 1ns/1ps
`include "serial_settings.svh"

module apb_word_regs (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  serial_pkg::reg_addr_t  paddr,
    input  serial_pkg::word_t      pwdata,
    output serial_pkg::word_t      prdata,
    output logic                   pslverr,
    output logic [`SER_NUM_CH-1:0] load,
    output serial_pkg::word_t      load_word,
    input  logic [`SER_NUM_CH-1:0] busy
);
    import serial_pkg::*;

    logic                   access;
    logic [`SER_NUM_CH-1:0] sel_ch;
    logic                   sel_status;
    logic                   mapped;
    logic                   busy_hit;
    // Last word accepted per channel, readable back
    word_t                  data_q [`SER_NUM_CH];

    assign access = psel && penable;

    assign sel_ch[0]  = (paddr == `SER_REG_CH0);
    assign sel_ch[1]  = (paddr == `SER_REG_CH1);
    assign sel_status = (paddr == `SER_REG_STATUS);
    assign mapped     = (|sel_ch) || sel_status;

    // Write aimed at a channel still shifting out its word
    assign busy_hit = pwrite && (|(sel_ch & busy));

    assign pslverr = access && (!mapped || busy_hit);

    // One-cycle strobe, only to an idle channel
    assign load      = {`SER_NUM_CH{access && pwrite}} & sel_ch & ~busy;
    assign load_word = pwdata;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (sel_status) begin
                prdata = word_t'(busy);
            end else begin
                for (int i = 0; i < `SER_NUM_CH; i++) begin
                    if (sel_ch[i]) begin
                        prdata = data_q[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `SER_NUM_CH; i++) begin
                data_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SER_NUM_CH; i++) begin
                if (load[i]) begin
                    data_q[i] <= pwdata;
                end
            end
        end
    end

endmodule

// ==== logic/byte_arbiter.sv ====
// Round-robin byte arbiter
`timescale 1ns/1ps

module byte_arbiter (
    input  logic              clk,
    input  logic              reset,
    byte_bus_if.sink          ch0,
    byte_bus_if.sink          ch1,
    output logic              byte_valid,
    output serial_pkg::byte_t byte_data,
    output serial_pkg::chan_t byte_chan,
    output logic              byte_last,
    input  logic              byte_ready
);
    import serial_pkg::*;

    arb_state_t state_q;
    chan_t      lock_chan_q;
    chan_t      rr_last_q;
    chan_t      pick;
    chan_t      sel;
    logic       xfer_last;

    // Free choice, the channel not served last wins a tie
    always_comb begin
        if (ch0.valid && ch1.valid) begin
            pick = ~rr_last_q;
        end else if (ch1.valid) begin
            pick = 1'b1;
        end else begin
            pick = 1'b0;
        end
    end

    assign sel = (state_q == ARB_LOCKED) ? lock_chan_q : pick;

    assign byte_valid = sel ? ch1.valid : ch0.valid;
    assign byte_data  = sel ? ch1.data  : ch0.data;
    assign byte_last  = sel ? ch1.last  : ch0.last;
    assign byte_chan  = sel;

    assign ch0.ready = byte_ready && (sel == 1'b0);
    assign ch1.ready = byte_ready && (sel == 1'b1);

    assign xfer_last = byte_valid && byte_ready && byte_last;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q     <= ARB_FREE;
            lock_chan_q <= 1'b0;
            rr_last_q   <= 1'b1;
        end else begin
            case (state_q)
                ARB_FREE: begin
                    // Lock on the first valid beat so a stalled beat keeps its source
                    if (xfer_last) begin
                        rr_last_q <= sel;
                    end else if (byte_valid) begin
                        state_q     <= ARB_LOCKED;
                        lock_chan_q <= sel;
                    end
                end
                ARB_LOCKED: begin
                    if (xfer_last) begin
                        state_q   <= ARB_FREE;
                        rr_last_q <= lock_chan_q;
                    end
                end
                default: state_q <= ARB_FREE;
            endcase
        end
    end

endmodule

// ==== logic/byte_bus_if.sv ====
// Byte stream bus
`timescale 1ns/1ps

interface byte_bus_if;
    import serial_pkg::*;

    logic  valid;
    logic  ready;
    byte_t data;
    // High on the final beat of a word
    logic  last;

    modport source (
        output valid, data, last,
        input  ready
    );

    modport sink (
        input  valid, data, last,
        output ready
    );
endinterface

// ==== logic/serial_pkg.sv ====
// Byte serializer types
`include "serial_settings.svh"

package serial_pkg;

    typedef logic [`SER_WORD_WIDTH-1:0] word_t;
    typedef logic [`SER_BYTE_WIDTH-1:0] byte_t;
    typedef logic [$clog2(`SER_NUM_CH)-1:0] chan_t;
    typedef logic [`SER_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [$clog2(`SER_WORD_WIDTH/`SER_BYTE_WIDTH)-1:0] beat_cnt_t;

    typedef enum logic {
        SER_IDLE,
        SER_SHIFT
    } ser_state_t;

    typedef enum logic {
        ARB_FREE,
        ARB_LOCKED
    } arb_state_t;

endpackage

// ==== logic/serial_settings.svh ====
// Byte serializer settings
`ifndef SERIAL_SETTINGS_SVH
`define SERIAL_SETTINGS_SVH

`define SER_WORD_WIDTH  32
`define SER_BYTE_WIDTH  8
`define SER_NUM_CH      2
`define SER_ADDR_WIDTH  4

// Register map
`define SER_REG_CH0     4'h0
`define SER_REG_CH1     4'h4
`define SER_REG_STATUS  4'h8

`endif

// ==== logic/serial_tx_top.sv ====
// Two-channel byte serializer top
`timescale 1ns/1ps
`include "serial_settings.svh"

module serial_tx_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  serial_pkg::reg_addr_t paddr,
    input  serial_pkg::word_t     pwdata,
    output serial_pkg::word_t     prdata,
    output logic                  pslverr,
    output logic                  byte_valid,
    output serial_pkg::byte_t     byte_data,
    output serial_pkg::chan_t     byte_chan,
    output logic                  byte_last,
    input  logic                  byte_ready
);
    import serial_pkg::*;

    logic [`SER_NUM_CH-1:0] load;
    logic [`SER_NUM_CH-1:0] busy;
    word_t                  load_word;

    byte_bus_if ch0_bus ();
    byte_bus_if ch1_bus ();

    apb_word_regs regs (
        .clk       (clk),
        .reset     (reset),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .load      (load),
        .load_word (load_word),
        .busy      (busy)
    );

    width_reducer #(
        .IN_WIDTH  (`SER_WORD_WIDTH),
        .OUT_WIDTH (`SER_BYTE_WIDTH)
    ) ch0_red (
        .clk       (clk),
        .reset     (reset),
        .load      (load[0]),
        .load_word (load_word),
        .busy      (busy[0]),
        .bus       (ch0_bus.source)
    );

    width_reducer #(
        .IN_WIDTH  (`SER_WORD_WIDTH),
        .OUT_WIDTH (`SER_BYTE_WIDTH)
    ) ch1_red (
        .clk       (clk),
        .reset     (reset),
        .load      (load[1]),
        .load_word (load_word),
        .busy      (busy[1]),
        .bus       (ch1_bus.source)
    );

    byte_arbiter arb (
        .clk        (clk),
        .reset      (reset),
        .ch0        (ch0_bus.sink),
        .ch1        (ch1_bus.sink),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_chan  (byte_chan),
        .byte_last  (byte_last),
        .byte_ready (byte_ready)
    );

endmodule

// ==== logic/width_reducer.sv ====
// Word to byte width reducer
`timescale 1ns/1ps

module width_reducer #(
    parameter int IN_WIDTH  = 32,
    // IN_WIDTH must be a multiple of this
    parameter int OUT_WIDTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                load,
    input  logic [IN_WIDTH-1:0] load_word,
    output logic                busy,
    byte_bus_if.source          bus
);
    import serial_pkg::*;

    localparam int RATIO = IN_WIDTH / OUT_WIDTH;
    localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

    ser_state_t          state_q;
    logic [IN_WIDTH-1:0] shift_q;
    logic [CNT_W-1:0]    beat_q;
    logic                valid_q;
    logic                last_beat;
    logic                xfer;

    assign last_beat = (beat_q == CNT_W'(RATIO - 1));
    assign xfer      = valid_q && bus.ready;

    assign busy      = (state_q != SER_IDLE);
    assign bus.valid = valid_q;
    assign bus.data  = byte_t'(shift_q[OUT_WIDTH-1:0]);
    assign bus.last  = valid_q && last_beat;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= SER_IDLE;
            beat_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                SER_IDLE: begin
                    if (load) begin
                        state_q <= SER_SHIFT;
                        beat_q  <= '0;
                    end
                end
                SER_SHIFT: begin
                    // First beat goes out the cycle after capture
                    if (!valid_q) begin
                        valid_q <= 1'b1;
                    end else if (xfer) begin
                        if (last_beat) begin
                            state_q <= SER_IDLE;
                            valid_q <= 1'b0;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                default: state_q <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == SER_IDLE && load) begin
            shift_q <= load_word;
        end else if (xfer) begin
            shift_q <= shift_q >> OUT_WIDTH;
        end
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/serial_pkg.sv
logic/byte_bus_if.sv
logic/apb_word_regs.sv
logic/width_reducer.sv
logic/byte_arbiter.sv
logic/serial_tx_top.sv
tb/serial_tx_assert.sv
tb/serial_tx_checker.sv
tb/serial_tx_tb.sv

// ==== tb/serial_tx_assert.sv ====
// Arbiter output assertions
`timescale 1ns/1ps

module serial_tx_assert (
    input logic              clk,
    input logic              reset,
    input logic              byte_valid,
    input logic              byte_ready,
    input logic              byte_last,
    input serial_pkg::byte_t byte_data,
    input serial_pkg::chan_t byte_chan
);

    // Count of failed assertions
    int fail_cnt = 0;

    valid_low_in_reset: assert property (@(posedge clk) reset |-> !byte_valid)
        else begin
            $error("byte_valid high while in reset");
            fail_cnt++;
        end

    // A stalled beat keeps its data and last flag
    beat_held: assert property (@(posedge clk) disable iff (reset)
        byte_valid && !byte_ready |=> byte_valid && $stable(byte_data) && $stable(byte_last))
        else begin
            $error("stalled beat changed before transfer");
            fail_cnt++;
        end

    chan_fixed_in_word: assert property (@(posedge clk) disable iff (reset)
        byte_valid && !(byte_ready && byte_last) |=> byte_valid && $stable(byte_chan))
        else begin
            $error("byte_chan changed inside a word");
            fail_cnt++;
        end

endmodule

// ==== tb/serial_tx_checker.sv ====
// Serializer scoreboard
`timescale 1ns/1ps
`include "serial_settings.svh"

module serial_tx_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  serial_pkg::reg_addr_t paddr,
    input  serial_pkg::word_t     pwdata,
    input  serial_pkg::word_t     prdata,
    input  logic                  pslverr,
    input  logic                  byte_valid,
    input  serial_pkg::byte_t     byte_data,
    input  serial_pkg::chan_t     byte_chan,
    input  logic                  byte_last,
    input  logic                  byte_ready,
    output int                    errors,
    output int                    pending_words
);
    import serial_pkg::*;

    word_t      exp_q [2][$];
    // Last accepted word per channel, as read back from its data register
    word_t      last_acc [2];
    int         acc_cyc [2];
    int         cyc;
    int         err_cnt = 0;
    int         beat;
    logic       in_word;
    chan_t      word_chan;
    chan_t      last_served;
    logic [1:0] present;
    logic       mapped;
    logic       exp_err;
    chan_t      ch;
    chan_t      exp_chan;
    word_t      head;

    task automatic mismatch(input string name, input word_t got, input word_t exp);
        $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        err_cnt++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR at cycle %0d: %s", cyc, msg);
        err_cnt++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_q[0].delete();
            exp_q[1].delete();
            last_acc[0] = '0;
            last_acc[1] = '0;
            cyc         = 0;
            beat        = 0;
            in_word     = 1'b0;
            last_served = 1'b1;
        end else begin
            cyc++;
            // APB first so a write sees the busy state before this edge
            if (psel && penable) begin
                mapped  = (paddr == `SER_REG_CH0) || (paddr == `SER_REG_CH1) ||
                          (paddr == `SER_REG_STATUS);
                ch      = (paddr == `SER_REG_CH1);
                exp_err = !mapped ||
                          (pwrite && paddr != `SER_REG_STATUS && exp_q[ch].size() != 0);
                if (pslverr !== exp_err) begin
                    mismatch("pslverr", word_t'(pslverr), word_t'(exp_err));
                end
                if (!pwrite && mapped) begin
                    if (paddr == `SER_REG_STATUS) begin
                        head = word_t'({exp_q[1].size() != 0, exp_q[0].size() != 0});
                    end else begin
                        head = last_acc[ch];
                    end
                    if (prdata !== head) begin
                        mismatch("prdata", prdata, head);
                    end
                end
                if (pwrite && paddr != `SER_REG_STATUS && !exp_err) begin
                    exp_q[ch].push_back(pwdata);
                    last_acc[ch] = pwdata;
                    acc_cyc[ch]  = cyc;
                end
            end else if (pslverr !== 1'b0) begin
                mismatch("pslverr", word_t'(pslverr), '0);
            end

            // A loaded word shows valid two cycles after its access
            for (int i = 0; i < 2; i++) begin
                present[i] = (exp_q[i].size() != 0) && (cyc >= acc_cyc[i] + 2);
            end
            if (!in_word) begin
                if (present != 2'b00) begin
                    exp_chan = (present == 2'b11) ? ~last_served : chan_t'(present[1]);
                    if (!byte_valid) begin
                        problem("byte_valid low although a word is ready");
                    end else begin
                        if (byte_chan !== exp_chan) begin
                            mismatch("byte_chan", word_t'(byte_chan), word_t'(exp_chan));
                        end
                        in_word   = 1'b1;
                        word_chan = byte_chan;
                        beat      = 0;
                    end
                end else if (byte_valid) begin
                    problem("byte_valid high with no word pending");
                end
            end

            if (in_word && byte_valid && byte_ready) begin
                if (byte_chan !== word_chan) begin
                    mismatch("byte_chan", word_t'(byte_chan), word_t'(word_chan));
                end else if (exp_q[byte_chan].size() == 0) begin
                    problem("byte transferred on a channel with no accepted word");
                end else begin
                    head = exp_q[byte_chan][0];
                    if (byte_data !== head[`SER_BYTE_WIDTH*beat +: `SER_BYTE_WIDTH]) begin
                        mismatch("byte_data", word_t'(byte_data),
                                 word_t'(head[`SER_BYTE_WIDTH*beat +: `SER_BYTE_WIDTH]));
                    end
                    if (byte_last !== (beat == 3)) begin
                        mismatch("byte_last", word_t'(byte_last), word_t'(beat == 3));
                    end
                    if (beat == 3) begin
                        void'(exp_q[byte_chan].pop_front());
                        in_word     = 1'b0;
                        last_served = byte_chan;
                        beat        = 0;
                    end else begin
                        beat++;
                    end
                end
            end
        end
        errors        <= err_cnt;
        pending_words <= exp_q[0].size() + exp_q[1].size();
    end

endmodule

// ==== tb/serial_tx_tb.sv ====
// Serializer testbench
`timescale 1ns/1ps
`include "serial_settings.svh"

module serial_tx_tb;
    import serial_pkg::*;

    // About 300 words of 4 beats with up to 4 stalled cycles per beat
    localparam int MAX_CYCLES = 300 * 4 * 5;

    logic      clk;
    logic      reset;
    logic      psel;
    logic      penable;
    logic      pwrite;
    reg_addr_t paddr;
    word_t     pwdata;
    word_t     prdata;
    logic      pslverr;
    logic      byte_valid;
    byte_t     byte_data;
    chan_t     byte_chan;
    logic      byte_last;
    logic      byte_ready;
    int        cycles = 0;
    int        ready_mode = 0;
    logic      ready_pat [1024];
    int        chk_errors;
    int        pending_words;
    int        tb_errors = 0;
    int        base_errors = 0;
    word_t     rdata;
    logic      err;
    reg_addr_t bad_addr;

    serial_tx_top dut (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .byte_chan  (byte_chan),
        .byte_last  (byte_last),
        .byte_ready (byte_ready)
    );

    serial_tx_checker scoreboard (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pslverr       (pslverr),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .byte_chan     (byte_chan),
        .byte_last     (byte_last),
        .byte_ready    (byte_ready),
        .errors        (chk_errors),
        .pending_words (pending_words)
    );

    bind byte_arbiter serial_tx_assert arb_assert (
        .clk        (clk),
        .reset      (reset),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .byte_last  (byte_last),
        .byte_data  (byte_data),
        .byte_chan  (byte_chan)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped, no end after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Sink ready per ready_mode
    always @(posedge clk) begin
        case (ready_mode)
            0: byte_ready <= 1'b1;
            1: byte_ready <= 1'b0;
            default: byte_ready <= ready_pat[cycles % 1024];
        endcase
    end

    task automatic apb_transfer(input reg_addr_t addr, input logic wr, input word_t data,
                                output logic slverr, output word_t rd);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        slverr = pslverr;
        rd     = prdata;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic random_writes(input int n);
        reg_addr_t addr;
        for (int i = 0; i < n; i++) begin
            addr = ($urandom % 2) ? `SER_REG_CH1 : `SER_REG_CH0;
            apb_transfer(addr, 1'b1, $urandom, err, rdata);
            repeat ($urandom % 3) @(posedge clk);
        end
    endtask

    // Poll STATUS until both channels are idle
    task automatic drain();
        word_t status;
        logic  slverr;
        status = '1;
        while (status[1:0] != 2'b00) begin
            apb_transfer(`SER_REG_STATUS, 1'b0, '0, slverr, status);
        end
        if (pending_words != 0) begin
            flag_error("accepted words never delivered");
        end
    endtask

    task automatic flag_error(input string msg);
        $display("ERROR: %s", msg);
        tb_errors++;
    endtask

    task automatic close_test(input string name);
        int total;
        @(posedge clk);
        total = chk_errors + tb_errors + dut.arb.arb_assert.fail_cnt;
        if (total == base_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, total - base_errors);
        end
        base_errors = total;
    endtask

    initial begin
        void'($urandom(32'hff1f));
        for (int i = 0; i < 1024; i++) begin
            ready_pat[i] = ($urandom % 3) != 0;
        end
        reset      = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        byte_ready = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        apb_transfer(`SER_REG_STATUS, 1'b0, '0, err, rdata);
        close_test("test 1 reset state");

        apb_transfer(`SER_REG_CH0, 1'b1, $urandom, err, rdata);
        drain();
        close_test("test 2 single word");

        random_writes(120);
        drain();
        close_test("test 3 both channels");

        ready_mode <= 1;
        apb_transfer(`SER_REG_CH0, 1'b1, $urandom, err, rdata);
        apb_transfer(`SER_REG_CH1, 1'b1, $urandom, err, rdata);
        apb_transfer(`SER_REG_STATUS, 1'b0, '0, err, rdata);
        if (rdata[1:0] != 2'b11) begin
            flag_error("channels not busy after their writes");
        end
        apb_transfer(`SER_REG_CH0, 1'b1, $urandom, err, rdata);
        if (!err) begin
            flag_error("write to busy channel 0 accepted");
        end
        apb_transfer(`SER_REG_CH1, 1'b1, $urandom, err, rdata);
        if (!err) begin
            flag_error("write to busy channel 1 accepted");
        end
        // Data registers still hold the accepted words
        apb_transfer(`SER_REG_CH0, 1'b0, '0, err, rdata);
        apb_transfer(`SER_REG_CH1, 1'b0, '0, err, rdata);
        ready_mode <= 0;
        drain();
        close_test("test 4 busy write");

        ready_mode <= 2;
        random_writes(160);
        drain();
        ready_mode <= 0;
        close_test("test 5 back-pressure");

        for (int i = 0; i < 8; i++) begin
            do begin
                bad_addr = reg_addr_t'($urandom % 16);
            end while (bad_addr == `SER_REG_CH0 || bad_addr == `SER_REG_CH1 ||
                       bad_addr == `SER_REG_STATUS);
            apb_transfer(bad_addr, 1'($urandom % 2), $urandom, err, rdata);
            if (!err) begin
                flag_error($sformatf("no pslverr for unmapped address %h", bad_addr));
            end
        end
        drain();
        close_test("test 6 unmapped access");

        $display("6 tests run, %0d errors", base_errors);
        if (base_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
